//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_dmem_subsys
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- hdl/dmem_pkg.sv
// Data memory bus types, command/width/response enums
// Byte enable helper shared by the TCM and the PULP bridge

package dmem_pkg;

    // Bus widths
    typedef logic [31:0] mem_addr_t;
    typedef logic [31:0] mem_data_t;
    typedef logic [3:0]  mem_be_t;

    typedef enum logic {
        MEM_CMD_RD = 1'b0,
        MEM_CMD_WR = 1'b1
    } mem_cmd_e;

    typedef enum logic [1:0] {
        MEM_WIDTH_BYTE  = 2'b00,
        MEM_WIDTH_HWORD = 2'b01,
        MEM_WIDTH_WORD  = 2'b10
    } mem_width_e;

    typedef enum logic [1:0] {
        MEM_RESP_IDLE   = 2'b00,
        MEM_RESP_RDY_OK = 2'b01,
        MEM_RESP_RDY_ER = 2'b10
    } mem_resp_e;

    // Lane enables from access width and address low bits
    function automatic mem_be_t mem_byte_en(mem_width_e width, logic [1:0] offs);
        mem_be_t be;
        case (width)
            MEM_WIDTH_BYTE:  be = mem_be_t'(4'b0001 << offs);
            MEM_WIDTH_HWORD: be = offs[1] ? 4'b1100 : 4'b0011;
            default:         be = 4'b1111;
        endcase
        return be;
    endfunction

endpackage : dmem_pkg

//--- hdl/dmem_pulp_bridge.sv
// Core memory protocol to PULP req/gnt/rvalid bridge

`timescale 1ns/100ps

module dmem_pulp_bridge import dmem_pkg::*; (
    input  logic       clk,
    input  logic       rst_n_i,
    // Core side
    input  logic       req_i,
    input  mem_cmd_e   cmd_i,
    input  mem_width_e width_i,
    input  mem_addr_t  addr_i,
    input  mem_data_t  wdata_i,
    output logic       req_ack_o,
    output mem_data_t  rdata_o,
    output mem_resp_e  resp_o,
    // PULP side
    output mem_addr_t  data_addr_o,
    output logic       data_req_o,
    output logic       data_we_o,
    output mem_be_t    data_be_o,
    output mem_data_t  data_wdata_o,
    input  logic       data_gnt_i,
    input  logic       data_rvalid_i,
    input  mem_data_t  data_rdata_i,
    input  logic       data_err_i
);

logic pending;      // Granted, waiting for rvalid

// --------------------
// Request channel
// --------------------
assign data_req_o  = req_i & ~pending;
assign data_addr_o = addr_i;
assign data_we_o   = (cmd_i == MEM_CMD_WR);
assign data_be_o   = mem_byte_en(width_i, addr_i[1:0]);
assign req_ack_o   = data_req_o & data_gnt_i;

// Replicate narrow data over all lanes
always_comb begin
    case (width_i)
        MEM_WIDTH_BYTE:  data_wdata_o = {4{wdata_i[7:0]}};
        MEM_WIDTH_HWORD: data_wdata_o = {2{wdata_i[15:0]}};
        default:         data_wdata_o = wdata_i;
    endcase
end

always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
        pending <= 1'b0;
    end else if (req_ack_o) begin
        pending <= 1'b1;
    end else if (data_rvalid_i) begin
        pending <= 1'b0;
    end
end

// --------------------
// Response channel
// --------------------
assign rdata_o = data_rdata_i;

always_comb begin
    if (pending && data_rvalid_i) begin
        resp_o = data_err_i ? MEM_RESP_RDY_ER : MEM_RESP_RDY_OK;
    end else begin
        resp_o = MEM_RESP_IDLE;
    end
end

endmodule : dmem_pulp_bridge

//--- hdl/dmem_router.sv
// Data memory router
// Address decode to TCM, timer or external port, response steering

`timescale 1ns/100ps

module dmem_router import dmem_pkg::*; #(
    parameter mem_addr_t TCM_ADDR_MASK      = 32'hFFFF_C000,
    parameter mem_addr_t TCM_ADDR_PATTERN   = 32'h0048_0000,
    parameter mem_addr_t TIMER_ADDR_MASK    = 32'hFFFF_FFE0,
    parameter mem_addr_t TIMER_ADDR_PATTERN = 32'h0049_0000
) (
    input  logic       clk,
    input  logic       rst_n_i,
    // Core side
    input  logic       dmem_req_i,
    input  mem_cmd_e   dmem_cmd_i,
    input  mem_width_e dmem_width_i,
    input  mem_addr_t  dmem_addr_i,
    input  mem_data_t  dmem_wdata_i,
    output logic       dmem_req_ack_o,
    output mem_data_t  dmem_rdata_o,
    output mem_resp_e  dmem_resp_o,
    // TCM port
    output logic       tcm_req_o,
    output mem_cmd_e   tcm_cmd_o,
    output mem_width_e tcm_width_o,
    output mem_addr_t  tcm_addr_o,
    output mem_data_t  tcm_wdata_o,
    input  logic       tcm_req_ack_i,
    input  mem_data_t  tcm_rdata_i,
    input  mem_resp_e  tcm_resp_i,
    // Timer port
    output logic       timer_req_o,
    output mem_cmd_e   timer_cmd_o,
    output mem_width_e timer_width_o,
    output mem_addr_t  timer_addr_o,
    output mem_data_t  timer_wdata_o,
    input  logic       timer_req_ack_i,
    input  mem_data_t  timer_rdata_i,
    input  mem_resp_e  timer_resp_i,
    // External port
    output logic       ext_req_o,
    output mem_cmd_e   ext_cmd_o,
    output mem_width_e ext_width_o,
    output mem_addr_t  ext_addr_o,
    output mem_data_t  ext_wdata_o,
    input  logic       ext_req_ack_i,
    input  mem_data_t  ext_rdata_i,
    input  mem_resp_e  ext_resp_i
);

typedef enum logic {
    ST_ADDR,
    ST_DATA
} router_state_e;

typedef enum logic [1:0] {
    PORT_EXT,
    PORT_TCM,
    PORT_TIMER
} port_sel_e;

router_state_e state;
port_sel_e     port_sel;        // Decoded from the current address
port_sel_e     port_sel_r;      // Port of the outstanding request
logic          sel_req_ack;
mem_data_t     sel_rdata;
mem_resp_e     sel_resp;
logic          resp_done;
logic          req_open;
logic          accept;

// --------------------
// Address decode
// --------------------
always_comb begin
    if ((dmem_addr_i & TCM_ADDR_MASK) == TCM_ADDR_PATTERN) begin
        port_sel = PORT_TCM;
    end else if ((dmem_addr_i & TIMER_ADDR_MASK) == TIMER_ADDR_PATTERN) begin
        port_sel = PORT_TIMER;
    end else begin
        port_sel = PORT_EXT;
    end
end

always_comb begin
    case (port_sel)
        PORT_TCM:   sel_req_ack = tcm_req_ack_i;
        PORT_TIMER: sel_req_ack = timer_req_ack_i;
        default:    sel_req_ack = ext_req_ack_i;
    endcase
end

// Response comes back from the port latched at acceptance
always_comb begin
    case (port_sel_r)
        PORT_TCM: begin
            sel_rdata = tcm_rdata_i;
            sel_resp  = tcm_resp_i;
        end
        PORT_TIMER: begin
            sel_rdata = timer_rdata_i;
            sel_resp  = timer_resp_i;
        end
        default: begin
            sel_rdata = ext_rdata_i;
            sel_resp  = ext_resp_i;
        end
    endcase
end

assign resp_done = (state == ST_DATA) && (sel_resp != MEM_RESP_IDLE);
assign req_open  = (state == ST_ADDR) || resp_done;   // Back-to-back on response cycle
assign accept    = dmem_req_i & req_open & sel_req_ack;

// --------------------
// Request fan-out
// --------------------
assign tcm_req_o     = dmem_req_i & req_open & (port_sel == PORT_TCM);
assign timer_req_o   = dmem_req_i & req_open & (port_sel == PORT_TIMER);
assign ext_req_o     = dmem_req_i & req_open & (port_sel == PORT_EXT);

assign tcm_cmd_o     = dmem_cmd_i;
assign tcm_width_o   = dmem_width_i;
assign tcm_addr_o    = dmem_addr_i;
assign tcm_wdata_o   = dmem_wdata_i;
assign timer_cmd_o   = dmem_cmd_i;
assign timer_width_o = dmem_width_i;
assign timer_addr_o  = dmem_addr_i;
assign timer_wdata_o = dmem_wdata_i;
assign ext_cmd_o     = dmem_cmd_i;
assign ext_width_o   = dmem_width_i;
assign ext_addr_o    = dmem_addr_i;
assign ext_wdata_o   = dmem_wdata_i;

assign dmem_req_ack_o = accept;
assign dmem_resp_o    = (state == ST_DATA) ? sel_resp : MEM_RESP_IDLE;
assign dmem_rdata_o   = sel_rdata;

// --------------------
// FSM
// --------------------
always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
        state      <= ST_ADDR;
        port_sel_r <= PORT_EXT;
    end else if (accept) begin
        state      <= ST_DATA;
        port_sel_r <= port_sel;
    end else if (resp_done) begin
        state      <= ST_ADDR;
    end
end

endmodule : dmem_router

//--- hdl/dmem_subsys_top.sv
// Data memory subsystem top level
// Reset synchronizer, address map and router, TCM, timer, PULP bridge instances

`timescale 1ns/100ps

module dmem_subsys_top import dmem_pkg::*; #(
    parameter mem_addr_t TCM_ADDR_MASK      = 32'hFFFF_C000,
    parameter mem_addr_t TCM_ADDR_PATTERN   = 32'h0048_0000,
    parameter mem_addr_t TIMER_ADDR_MASK    = 32'hFFFF_FFE0,
    parameter mem_addr_t TIMER_ADDR_PATTERN = 32'h0049_0000
) (
    input  logic       clk,
    input  logic       arst_n_i,
    // Core data port
    input  logic       dmem_req_i,
    input  mem_cmd_e   dmem_cmd_i,
    input  mem_width_e dmem_width_i,
    input  mem_addr_t  dmem_addr_i,
    input  mem_data_t  dmem_wdata_i,
    output logic       dmem_req_ack_o,
    output mem_data_t  dmem_rdata_o,
    output mem_resp_e  dmem_resp_o,
    output logic       timer_irq_o,
    // PULP data bus
    output mem_addr_t  data_addr_o,
    output logic       data_req_o,
    output logic       data_we_o,
    output mem_be_t    data_be_o,
    output mem_data_t  data_wdata_o,
    input  logic       data_gnt_i,
    input  logic       data_rvalid_i,
    input  mem_data_t  data_rdata_i,
    input  logic       data_err_i
);

// Window size follows from the mask
localparam int unsigned TCM_SIZE = int'(mem_addr_t'(~TCM_ADDR_MASK + 32'd1));

logic [1:0] rst_sync;
logic       rst_n;

// Router to TCM
logic       tcm_req;
mem_cmd_e   tcm_cmd;
mem_width_e tcm_width;
mem_addr_t  tcm_addr;
mem_data_t  tcm_wdata;
logic       tcm_req_ack;
mem_data_t  tcm_rdata;
mem_resp_e  tcm_resp;

// Router to timer
logic       timer_req;
mem_cmd_e   timer_cmd;
mem_width_e timer_width;
mem_addr_t  timer_addr;
mem_data_t  timer_wdata;
logic       timer_req_ack;
mem_data_t  timer_rdata;
mem_resp_e  timer_resp;

// Router to PULP bridge
logic       ext_req;
mem_cmd_e   ext_cmd;
mem_width_e ext_width;
mem_addr_t  ext_addr;
mem_data_t  ext_wdata;
logic       ext_req_ack;
mem_data_t  ext_rdata;
mem_resp_e  ext_resp;

// --------------------
// Reset synchronizer
// --------------------
always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
        rst_sync <= 2'b00;
    end else begin
        rst_sync <= {rst_sync[0], 1'b1};
    end
end

assign rst_n = rst_sync[1];     // Async assert, sync release

// --------------------
// Instances
// --------------------
dmem_router #(
    .TCM_ADDR_MASK      (TCM_ADDR_MASK),
    .TCM_ADDR_PATTERN   (TCM_ADDR_PATTERN),
    .TIMER_ADDR_MASK    (TIMER_ADDR_MASK),
    .TIMER_ADDR_PATTERN (TIMER_ADDR_PATTERN)
) i_router (
    .clk             (clk),
    .rst_n_i         (rst_n),
    .dmem_req_i      (dmem_req_i),
    .dmem_cmd_i      (dmem_cmd_i),
    .dmem_width_i    (dmem_width_i),
    .dmem_addr_i     (dmem_addr_i),
    .dmem_wdata_i    (dmem_wdata_i),
    .dmem_req_ack_o  (dmem_req_ack_o),
    .dmem_rdata_o    (dmem_rdata_o),
    .dmem_resp_o     (dmem_resp_o),
    .tcm_req_o       (tcm_req),
    .tcm_cmd_o       (tcm_cmd),
    .tcm_width_o     (tcm_width),
    .tcm_addr_o      (tcm_addr),
    .tcm_wdata_o     (tcm_wdata),
    .tcm_req_ack_i   (tcm_req_ack),
    .tcm_rdata_i     (tcm_rdata),
    .tcm_resp_i      (tcm_resp),
    .timer_req_o     (timer_req),
    .timer_cmd_o     (timer_cmd),
    .timer_width_o   (timer_width),
    .timer_addr_o    (timer_addr),
    .timer_wdata_o   (timer_wdata),
    .timer_req_ack_i (timer_req_ack),
    .timer_rdata_i   (timer_rdata),
    .timer_resp_i    (timer_resp),
    .ext_req_o       (ext_req),
    .ext_cmd_o       (ext_cmd),
    .ext_width_o     (ext_width),
    .ext_addr_o      (ext_addr),
    .ext_wdata_o     (ext_wdata),
    .ext_req_ack_i   (ext_req_ack),
    .ext_rdata_i     (ext_rdata),
    .ext_resp_i      (ext_resp)
);

dmem_tcm #(
    .TCM_SIZE (TCM_SIZE)
) i_tcm (
    .clk       (clk),
    .rst_n_i   (rst_n),
    .req_i     (tcm_req),
    .cmd_i     (tcm_cmd),
    .width_i   (tcm_width),
    .addr_i    (tcm_addr),
    .wdata_i   (tcm_wdata),
    .req_ack_o (tcm_req_ack),
    .rdata_o   (tcm_rdata),
    .resp_o    (tcm_resp)
);

dmem_timer i_timer (
    .clk         (clk),
    .rst_n_i     (rst_n),
    .req_i       (timer_req),
    .cmd_i       (timer_cmd),
    .width_i     (timer_width),
    .addr_i      (timer_addr),
    .wdata_i     (timer_wdata),
    .req_ack_o   (timer_req_ack),
    .rdata_o     (timer_rdata),
    .resp_o      (timer_resp),
    .timer_irq_o (timer_irq_o)
);

dmem_pulp_bridge i_pulp_bridge (
    .clk           (clk),
    .rst_n_i       (rst_n),
    .req_i         (ext_req),
    .cmd_i         (ext_cmd),
    .width_i       (ext_width),
    .addr_i        (ext_addr),
    .wdata_i       (ext_wdata),
    .req_ack_o     (ext_req_ack),
    .rdata_o       (ext_rdata),
    .resp_o        (ext_resp),
    .data_addr_o   (data_addr_o),
    .data_req_o    (data_req_o),
    .data_we_o     (data_we_o),
    .data_be_o     (data_be_o),
    .data_wdata_o  (data_wdata_o),
    .data_gnt_i    (data_gnt_i),
    .data_rvalid_i (data_rvalid_i),
    .data_rdata_i  (data_rdata_i),
    .data_err_i    (data_err_i)
);

endmodule : dmem_subsys_top

//--- hdl/dmem_tcm.sv
// Tightly coupled data memory, single port, byte writable

`timescale 1ns/100ps

module dmem_tcm import dmem_pkg::*; #(
    parameter int unsigned TCM_SIZE = 16384     // Bytes
) (
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic       req_i,
    input  mem_cmd_e   cmd_i,
    input  mem_width_e width_i,
    input  mem_addr_t  addr_i,
    input  mem_data_t  wdata_i,
    output logic       req_ack_o,
    output mem_data_t  rdata_o,
    output mem_resp_e  resp_o
);

localparam int unsigned WORDS = TCM_SIZE / 4;
localparam int unsigned AW    = $clog2(TCM_SIZE);

logic [AW-3:0] word_idx;
mem_be_t       be;
mem_data_t     wdata_sh;
mem_data_t     mem [WORDS];

assign word_idx  = addr_i[AW-1:2];                      // Offset within the window
assign be        = mem_byte_en(width_i, addr_i[1:0]);
assign wdata_sh  = wdata_i << {addr_i[1:0], 3'b000};    // Move data to its lanes
assign req_ack_o = req_i;

always_ff @(posedge clk) begin
    if (req_i) begin
        if (cmd_i == MEM_CMD_WR) begin
            for (int i = 0; i < 4; i++) begin
                if (be[i]) begin
                    mem[word_idx][8*i +: 8] <= wdata_sh[8*i +: 8];
                end
            end
        end
        rdata_o <= mem[word_idx];   // Full aligned word
    end
end

// Every access completes one cycle later
always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
        resp_o <= MEM_RESP_IDLE;
    end else begin
        resp_o <= req_i ? MEM_RESP_RDY_OK : MEM_RESP_IDLE;
    end
end

endmodule : dmem_tcm

//--- hdl/dmem_timer.sv
// Memory-mapped machine timer
// Control, mtime and mtimecmp registers with compare interrupt

`timescale 1ns/100ps

module dmem_timer import dmem_pkg::*; (
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic       req_i,
    input  mem_cmd_e   cmd_i,
    input  mem_width_e width_i,
    input  mem_addr_t  addr_i,
    input  mem_data_t  wdata_i,
    output logic       req_ack_o,
    output mem_data_t  rdata_o,
    output mem_resp_e  resp_o,
    output logic       timer_irq_o
);

// Register offsets
localparam logic [4:0] OFFS_CTRL        = 5'h00;
localparam logic [4:0] OFFS_MTIME_LO    = 5'h08;
localparam logic [4:0] OFFS_MTIME_HI    = 5'h0C;
localparam logic [4:0] OFFS_MTIMECMP_LO = 5'h10;
localparam logic [4:0] OFFS_MTIMECMP_HI = 5'h14;

logic [4:0]  offs;
logic        acc_ok;
logic        wr_en;
logic        ctrl_en;
logic [63:0] mtime;
logic [63:0] mtimecmp;

assign offs      = addr_i[4:0];
assign req_ack_o = req_i;

always_comb begin
    case (offs)
        OFFS_CTRL, OFFS_MTIME_LO, OFFS_MTIME_HI,
        OFFS_MTIMECMP_LO, OFFS_MTIMECMP_HI: acc_ok = (width_i == MEM_WIDTH_WORD);
        default:                            acc_ok = 1'b0;
    endcase
end

assign wr_en = req_i & acc_ok & (cmd_i == MEM_CMD_WR);

// --------------------
// Registers
// --------------------
always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
        ctrl_en  <= 1'b0;
        mtimecmp <= '1;                 // No interrupt until programmed
    end else if (wr_en) begin
        case (offs)
            OFFS_CTRL:        ctrl_en         <= wdata_i[0];
            OFFS_MTIMECMP_LO: mtimecmp[31:0]  <= wdata_i;
            OFFS_MTIMECMP_HI: mtimecmp[63:32] <= wdata_i;
            default: ;
        endcase
    end
end

// Software write takes priority over the increment
always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
        mtime <= '0;
    end else if (wr_en && offs == OFFS_MTIME_LO) begin
        mtime[31:0] <= wdata_i;
    end else if (wr_en && offs == OFFS_MTIME_HI) begin
        mtime[63:32] <= wdata_i;
    end else if (ctrl_en) begin
        mtime <= mtime + 64'd1;
    end
end

always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
        timer_irq_o <= 1'b0;
    end else begin
        timer_irq_o <= (mtime >= mtimecmp);
    end
end

// --------------------
// Read and response
// --------------------
always_ff @(posedge clk) begin
    if (req_i) begin
        case (offs)
            OFFS_CTRL:        rdata_o <= {31'd0, ctrl_en};
            OFFS_MTIME_LO:    rdata_o <= mtime[31:0];
            OFFS_MTIME_HI:    rdata_o <= mtime[63:32];
            OFFS_MTIMECMP_LO: rdata_o <= mtimecmp[31:0];
            OFFS_MTIMECMP_HI: rdata_o <= mtimecmp[63:32];
            default:          rdata_o <= '0;
        endcase
    end
end

always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
        resp_o <= MEM_RESP_IDLE;
    end else if (req_i) begin
        resp_o <= acc_ok ? MEM_RESP_RDY_OK : MEM_RESP_RDY_ER;
    end else begin
        resp_o <= MEM_RESP_IDLE;
    end
end

endmodule : dmem_timer

//--- src.f
hdl/dmem_pkg.sv
hdl/dmem_router.sv
hdl/dmem_tcm.sv
hdl/dmem_timer.sv
hdl/dmem_pulp_bridge.sv
hdl/dmem_subsys_top.sv
testbench/dmem_subsys_props.sv
testbench/tb_dmem_subsys.sv

//--- testbench/dmem_subsys_props.sv
// Bound assertions on the core-side handshake and the PULP request channel

`timescale 1ns/100ps

module dmem_subsys_props import dmem_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      dmem_req_i,
    input  logic      dmem_req_ack_i,
    input  mem_resp_e dmem_resp_i,
    input  logic      data_req_i,
    input  mem_addr_t data_addr_i,
    input  logic      data_we_i,
    input  mem_be_t   data_be_i,
    input  mem_data_t data_wdata_i,
    input  logic      data_gnt_i
);

logic outstanding;      // Accepted, response not yet seen

always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
        outstanding <= 1'b0;
    end else if (dmem_req_i && dmem_req_ack_i) begin
        outstanding <= 1'b1;
    end else if (dmem_resp_i != MEM_RESP_IDLE) begin
        outstanding <= 1'b0;
    end
end

// A second request only on the response cycle of the first
a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n_i)
    dmem_req_ack_i |-> dmem_req_i && (!outstanding || dmem_resp_i != MEM_RESP_IDLE))
    else $error("dmem req_ack high without req or with a request still outstanding");

a_resp_needs_req: assert property (@(posedge clk) disable iff (!rst_n_i)
    (dmem_resp_i != MEM_RESP_IDLE) |-> outstanding)
    else $error("dmem resp shown with no request outstanding");

// Request fields hold until granted
a_pulp_req_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
    (data_req_i && !data_gnt_i) |=> (data_req_i && $stable(data_addr_i)
        && $stable(data_we_i) && $stable(data_be_i) && $stable(data_wdata_i)))
    else $error("PULP request dropped or changed before grant");

endmodule : dmem_subsys_props

bind dmem_subsys_top dmem_subsys_props i_props (
    .clk            (clk),
    .rst_n_i        (rst_n),
    .dmem_req_i     (dmem_req_i),
    .dmem_req_ack_i (dmem_req_ack_o),
    .dmem_resp_i    (dmem_resp_o),
    .data_req_i     (data_req_o),
    .data_addr_i    (data_addr_o),
    .data_we_i      (data_we_o),
    .data_be_i      (data_be_o),
    .data_wdata_i   (data_wdata_o),
    .data_gnt_i     (data_gnt_i)
);

//--- testbench/tb_dmem_subsys.sv
// Testbench for the data memory subsystem
// Clock, reset, PULP memory model, stimulus table, checks and timeout

`timescale 1ns/100ps

module tb_dmem_subsys import dmem_pkg::*; ;

localparam int RESET_CYCLES   = 8;
localparam int NUM_ROWS       = 32;
localparam int TIMEOUT_CYCLES = RESET_CYCLES + (NUM_ROWS + 1) * 10 + 200;

localparam mem_addr_t TCM_BASE   = 32'h0048_0000;
localparam mem_addr_t TIMER_BASE = 32'h0049_0000;
localparam mem_addr_t EXT_BASE   = 32'h2000_0000;
localparam mem_addr_t ERR_BASE   = 32'hE000_0000;   // Model flags errors here

// Short names for the table
localparam mem_cmd_e   RD   = MEM_CMD_RD;
localparam mem_cmd_e   WR   = MEM_CMD_WR;
localparam mem_width_e BYTE = MEM_WIDTH_BYTE;
localparam mem_width_e HALF = MEM_WIDTH_HWORD;
localparam mem_width_e WORD = MEM_WIDTH_WORD;
localparam mem_resp_e  OK   = MEM_RESP_RDY_OK;
localparam mem_resp_e  ERR  = MEM_RESP_RDY_ER;

typedef struct packed {
    mem_cmd_e   cmd;
    mem_width_e width;
    mem_addr_t  addr;
    mem_data_t  wdata;
    mem_data_t  exp_rdata;
    mem_resp_e  exp_resp;
    mem_be_t    exp_be;     // Zero for rows that must stay off the PULP bus
} row_t;

logic       clk;
logic       arst_n;
logic       dmem_req;
mem_cmd_e   dmem_cmd;
mem_width_e dmem_width;
mem_addr_t  dmem_addr;
mem_data_t  dmem_wdata;
logic       dmem_req_ack;
mem_data_t  dmem_rdata;
mem_resp_e  dmem_resp;
logic       timer_irq;
mem_addr_t  data_addr;
logic       data_req;
logic       data_we;
mem_be_t    data_be;
mem_data_t  data_wdata;
logic       data_gnt;
logic       data_rvalid;
mem_data_t  data_rdata;
logic       data_err;

row_t      table_rows [NUM_ROWS];
int        row_cnt;
int        err_cnt;
int        cycle_cnt = 0;
mem_data_t got_rdata;
mem_resp_e got_resp;

// External memory model state
mem_data_t   ext_mem [256];
logic [31:0] rng_state;
logic        gnt_armed;
int          gnt_delay;
int          bus_cnt;           // Granted transfers so far
mem_addr_t   bus_addr;
logic        bus_we;
mem_be_t     bus_be;
mem_data_t   bus_wdata;
logic        req_s;
logic        gnt_s;
logic        we_s;
logic        err_s;
mem_addr_t   addr_s;
mem_be_t     be_s;
mem_data_t   wdata_s;

dmem_subsys_top UUT (
    .clk            (clk),
    .arst_n_i       (arst_n),
    .dmem_req_i     (dmem_req),
    .dmem_cmd_i     (dmem_cmd),
    .dmem_width_i   (dmem_width),
    .dmem_addr_i    (dmem_addr),
    .dmem_wdata_i   (dmem_wdata),
    .dmem_req_ack_o (dmem_req_ack),
    .dmem_rdata_o   (dmem_rdata),
    .dmem_resp_o    (dmem_resp),
    .timer_irq_o    (timer_irq),
    .data_addr_o    (data_addr),
    .data_req_o     (data_req),
    .data_we_o      (data_we),
    .data_be_o      (data_be),
    .data_wdata_o   (data_wdata),
    .data_gnt_i     (data_gnt),
    .data_rvalid_i  (data_rvalid),
    .data_rdata_i   (data_rdata),
    .data_err_i     (data_err)
);

always #20 clk = ~clk;

always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

initial begin : watchdog
    wait (cycle_cnt >= TIMEOUT_CYCLES);
    $display("Timeout after %0d cycles, a request or the interrupt never completed", cycle_cnt);
    $display("TEST FAILED");
    $finish;
end

// --------------------
// Helpers
// --------------------
function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

// Lane i carries byte (i mod access size) of the write data
function automatic mem_data_t lane_replicate(input mem_width_e width, input mem_data_t data);
    mem_data_t rep;
    int        nbytes;
    nbytes = (width == MEM_WIDTH_BYTE) ? 1 : (width == MEM_WIDTH_HWORD) ? 2 : 4;
    for (int i = 0; i < 4; i++) begin
        rep[8*i +: 8] = data[8*(i % nbytes) +: 8];
    end
    return rep;
endfunction

task automatic report_mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
    $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
    err_cnt++;
endtask

task automatic add_row(input mem_cmd_e cmd, input mem_width_e width, input mem_addr_t addr,
                       input mem_data_t wdata, input mem_data_t exp_rdata,
                       input mem_resp_e exp_resp, input mem_be_t exp_be);
    if (row_cnt < NUM_ROWS) begin
        table_rows[row_cnt].cmd       = cmd;
        table_rows[row_cnt].width     = width;
        table_rows[row_cnt].addr      = addr;
        table_rows[row_cnt].wdata     = wdata;
        table_rows[row_cnt].exp_rdata = exp_rdata;
        table_rows[row_cnt].exp_resp  = exp_resp;
        table_rows[row_cnt].exp_be    = exp_be;
    end
    row_cnt++;
endtask

// Hold the request until accepted, then wait for its response
task automatic run_access(input mem_cmd_e cmd, input mem_width_e width, input mem_addr_t addr,
                          input mem_data_t wdata);
    @(posedge clk);
    #2;
    dmem_req   = 1'b1;
    dmem_cmd   = cmd;
    dmem_width = width;
    dmem_addr  = addr;
    dmem_wdata = wdata;
    do begin
        @(negedge clk);
    end while (!dmem_req_ack);
    @(posedge clk);             // Accepting edge
    #2;
    dmem_req = 1'b0;
    do begin
        @(negedge clk);
    end while (dmem_resp == MEM_RESP_IDLE);
    got_resp  = dmem_resp;
    got_rdata = dmem_rdata;
endtask

// --------------------
// PULP memory model
// --------------------
initial begin
    data_gnt    = 1'b0;
    data_rvalid = 1'b0;
    data_rdata  = '0;
    data_err    = 1'b0;
    gnt_armed   = 1'b0;
    gnt_delay   = 0;
    bus_cnt     = 0;
    bus_addr    = '0;
    bus_we      = 1'b0;
    bus_be      = '0;
    bus_wdata   = '0;
    rng_state   = 32'h56ca;
    for (int i = 0; i < 256; i++) begin
        ext_mem[i] = 32'h5A00_0000 | (32'(i) << 2);     // Byte address of the word
    end
end

always begin : ext_mem_model
    @(negedge clk);
    req_s   = data_req;
    gnt_s   = data_gnt;
    addr_s  = data_addr;
    we_s    = data_we;
    be_s    = data_be;
    wdata_s = data_wdata;
    @(posedge clk);
    #2;
    data_rvalid = 1'b0;
    data_err    = 1'b0;
    if (req_s && gnt_s) begin
        data_gnt  = 1'b0;
        gnt_armed = 1'b0;
        bus_cnt++;
        bus_addr  = addr_s;
        bus_we    = we_s;
        bus_be    = be_s;
        bus_wdata = wdata_s;
        err_s     = (addr_s[31:28] == 4'hE);
        if (we_s && !err_s) begin
            for (int i = 0; i < 4; i++) begin
                if (be_s[i]) begin
                    ext_mem[addr_s[9:2]][8*i +: 8] = wdata_s[8*i +: 8];
                end
            end
        end
        data_rvalid = 1'b1;     // One cycle after the grant
        data_err    = err_s;
        data_rdata  = err_s ? 32'h0 : ext_mem[addr_s[9:2]];
    end else if (req_s) begin
        if (!gnt_armed) begin
            rng_state = xorshift32(rng_state);
            gnt_delay = int'(rng_state[1:0]);           // 0 to 3 cycles
            gnt_armed = 1'b1;
        end
        if (gnt_delay == 0) begin
            data_gnt = 1'b1;
        end else begin
            gnt_delay--;
        end
    end
end

// --------------------
// Stimulus
// --------------------
initial begin : stimulus
    int cnt_before;

    clk        = 1'b0;
    arst_n     = 1'b0;
    dmem_req   = 1'b0;
    dmem_cmd   = MEM_CMD_RD;
    dmem_width = MEM_WIDTH_WORD;
    dmem_addr  = '0;
    dmem_wdata = '0;
    err_cnt    = 0;
    row_cnt    = 0;

    // cmd, width, addr, wdata, exp rdata, exp resp, exp data_be_o
    add_row(RD, WORD, TIMER_BASE + 'h08, 32'h0,         32'h0,         OK,  4'h0);
    add_row(RD, WORD, TIMER_BASE + 'h10, 32'h0,         32'hFFFF_FFFF, OK,  4'h0);
    add_row(WR, WORD, TCM_BASE + 'h100,  32'h1122_3344, 32'h0,         OK,  4'h0);
    add_row(WR, BYTE, TCM_BASE + 'h101,  32'h0000_00AB, 32'h0,         OK,  4'h0);
    add_row(WR, HALF, TCM_BASE + 'h102,  32'h0000_CDEF, 32'h0,         OK,  4'h0);
    add_row(RD, WORD, TCM_BASE + 'h100,  32'h0,         32'hCDEF_AB44, OK,  4'h0);
    add_row(WR, WORD, TCM_BASE + 'h204,  32'hDEAD_BEEF, 32'h0,         OK,  4'h0);
    add_row(WR, BYTE, TCM_BASE + 'h207,  32'h0000_0012, 32'h0,         OK,  4'h0);
    add_row(RD, WORD, TCM_BASE + 'h204,  32'h0,         32'h12AD_BEEF, OK,  4'h0);
    add_row(WR, WORD, EXT_BASE + 'h40,   32'h0BAD_F00D, 32'h0,         OK,  4'hF);
    add_row(WR, BYTE, EXT_BASE + 'h42,   32'h0000_0077, 32'h0,         OK,  4'h4);
    add_row(WR, HALF, EXT_BASE + 'h40,   32'h0000_1234, 32'h0,         OK,  4'h3);
    add_row(RD, WORD, EXT_BASE + 'h40,   32'h0,         32'h0B77_1234, OK,  4'hF);
    add_row(WR, BYTE, EXT_BASE + 'h47,   32'h0000_00A5, 32'h0,         OK,  4'h8);
    add_row(RD, HALF, EXT_BASE + 'h46,   32'h0,         32'hA500_0044, OK,  4'hC);
    add_row(RD, WORD, EXT_BASE + 'h80,   32'h0,         32'h5A00_0080, OK,  4'hF);
    add_row(RD, WORD, ERR_BASE + 'h10,   32'h0,         32'h0,         ERR, 4'hF);
    add_row(WR, WORD, ERR_BASE + 'h20,   32'h5555_AAAA, 32'h0,         ERR, 4'hF);
    add_row(RD, HALF, TIMER_BASE + 'h08, 32'h0,         32'h0,         ERR, 4'h0);
    add_row(RD, WORD, TIMER_BASE + 'h04, 32'h0,         32'h0,         ERR, 4'h0);
    add_row(WR, WORD, TIMER_BASE + 'h18, 32'h0000_0001, 32'h0,         ERR, 4'h0);
    // Interleaved targets
    add_row(WR, WORD, TCM_BASE + 'h300,  32'h1357_9BDF, 32'h0,         OK,  4'h0);
    add_row(RD, WORD, EXT_BASE + 'h40,   32'h0,         32'h0B77_1234, OK,  4'hF);
    add_row(RD, WORD, TIMER_BASE + 'h14, 32'h0,         32'hFFFF_FFFF, OK,  4'h0);
    add_row(RD, WORD, TCM_BASE + 'h300,  32'h0,         32'h1357_9BDF, OK,  4'h0);
    add_row(WR, WORD, EXT_BASE + 'hC0,   32'h2468_ACE0, 32'h0,         OK,  4'hF);
    add_row(RD, WORD, TCM_BASE + 'h100,  32'h0,         32'hCDEF_AB44, OK,  4'h0);
    add_row(RD, WORD, EXT_BASE + 'hC0,   32'h0,         32'h2468_ACE0, OK,  4'hF);
    // Timer compare at 50, then enable
    add_row(WR, WORD, TIMER_BASE + 'h10, 32'h0000_0032, 32'h0,         OK,  4'h0);
    add_row(WR, WORD, TIMER_BASE + 'h14, 32'h0,         32'h0,         OK,  4'h0);
    add_row(RD, WORD, TIMER_BASE + 'h10, 32'h0,         32'h0000_0032, OK,  4'h0);
    add_row(WR, WORD, TIMER_BASE + 'h00, 32'h0000_0001, 32'h0,         OK,  4'h0);
    if (row_cnt != NUM_ROWS) begin
        $display("Stimulus table holds %0d rows instead of %0d", row_cnt, NUM_ROWS);
        err_cnt++;
    end

    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    arst_n = 1'b1;
    repeat (3) @(posedge clk);      // Internal reset release
    @(negedge clk);
    if (dmem_req_ack !== 1'b0) report_mismatch("dmem_req_ack_o", 32'h0, 32'(dmem_req_ack));
    if (dmem_resp !== MEM_RESP_IDLE) report_mismatch("dmem_resp_o", 32'h0, 32'(dmem_resp));
    if (data_req !== 1'b0) report_mismatch("data_req_o", 32'h0, 32'(data_req));
    if (timer_irq !== 1'b0) report_mismatch("timer_irq_o", 32'h0, 32'(timer_irq));

    for (int i = 0; i < NUM_ROWS; i++) begin
        cnt_before = bus_cnt;
        run_access(table_rows[i].cmd, table_rows[i].width, table_rows[i].addr,
                   table_rows[i].wdata);
        if (got_resp !== table_rows[i].exp_resp) begin
            report_mismatch("dmem_resp_o", 32'(table_rows[i].exp_resp), 32'(got_resp));
        end
        if (table_rows[i].cmd == RD && table_rows[i].exp_resp == OK &&
            got_rdata !== table_rows[i].exp_rdata) begin
            report_mismatch("dmem_rdata_o", table_rows[i].exp_rdata, got_rdata);
        end
        if (table_rows[i].exp_be != 4'h0) begin
            if (bus_cnt == cnt_before) begin
                $display("Row %0d reached no transfer on the PULP bus", i);
                err_cnt++;
            end
            if (bus_addr !== table_rows[i].addr) begin
                report_mismatch("data_addr_o", table_rows[i].addr, bus_addr);
            end
            if (bus_we !== (table_rows[i].cmd == WR)) begin
                report_mismatch("data_we_o", 32'(table_rows[i].cmd == WR), 32'(bus_we));
            end
            if (bus_be !== table_rows[i].exp_be) begin
                report_mismatch("data_be_o", 32'(table_rows[i].exp_be), 32'(bus_be));
            end
            if (table_rows[i].cmd == WR &&
                bus_wdata !== lane_replicate(table_rows[i].width, table_rows[i].wdata)) begin
                report_mismatch("data_wdata_o",
                                lane_replicate(table_rows[i].width, table_rows[i].wdata),
                                bus_wdata);
            end
        end else if (bus_cnt != cnt_before) begin
            $display("Row %0d leaked a transfer onto the PULP bus", i);
            err_cnt++;
        end
    end

    // Counter runs up to the compare value
    while (!timer_irq) @(negedge clk);
    run_access(RD, WORD, TIMER_BASE + 'h08, 32'h0);
    if (got_resp !== OK) report_mismatch("dmem_resp_o", 32'(OK), 32'(got_resp));
    if ($isunknown(got_rdata) || got_rdata < 32'd50) begin
        $display("FAIL t=%0t mtime expected >= 50 got %0d", $time, got_rdata);
        err_cnt++;
    end

    $display("Rows applied: %0d, errors: %0d", NUM_ROWS + 1, err_cnt);
    if (err_cnt == 0) begin
        $display("TEST OK");
    end else begin
        $display("TEST FAILED");
    end
    $finish;
end

endmodule : tb_dmem_subsys
